/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_wino_inv
FLIST     ?= wino_inv_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= >>> PASS

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* tb/tb_wino_inv.sv */
`timescale 1ns/10ps
`include "wino_consts.svh"

module tb_wino_inv import wino_pkg::*; ();

	localparam int NREC = 7;
	localparam int RECW = 54; // Shift, relu, 36 inputs, 16 pixels.

	logic clk;
	logic i_rst_n;
	logic i_valid;
	wino_row_t i_row;
	logic i_cfg_we;
	logic i_cfg_addr;
	logic [7:0] i_cfg_wdata;
	logic o_valid;
	wino_pix_row_t o_pix;

	logic [31:0] vec [0:NREC*RECW-1];
	acc_t tile [0:5][0:5];
	logic [63:0] exp_q [$];
	int err_cnt, pass_cnt, fail_cnt, e0;
	int cyc, start_cyc, rise_cyc, run_len, last_run;
	int cur_shift, cur_relu;
	integer seed;
	logic prev_v;

	wino_inv_top uut (
		.clk(clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_row(i_row),
		.i_cfg_we(i_cfg_we), .i_cfg_addr(i_cfg_addr), .i_cfg_wdata(i_cfg_wdata),
		.o_valid(o_valid), .o_pix(o_pix)
	);

	always #20 clk = ~clk;
	always @(posedge clk) cyc <= cyc + 1;

	// One row of the inverse transform matrix.
	function automatic acc_t a_row(int j, acc_t a, acc_t b, acc_t c, acc_t d, acc_t e, acc_t f);
		case (j)
			0: return a + b + c + d + e;
			1: return b - c + (d <<< 1) - (e <<< 1);
			2: return b + c + (d <<< 2) + (e <<< 2);
			default: return b - c + (d <<< 3) - (e <<< 3) + f;
		endcase
	endfunction

	function automatic logic [15:0] qnt(acc_t v);
		acc_t s;
		if (cur_relu != 0 && v < 0) return 16'h0000;
		s = v >>> cur_shift;
		if (s > 32767) return 16'h7fff;
		if (s < -32768) return 16'h8000;
		return s[15:0];
	endfunction

	task automatic model_tile();
		acc_t mid [0:5][0:3];
		logic [63:0] r;
		for (int k = 0; k < 6; k++)
			for (int j = 0; j < 4; j++)
				mid[k][j] = a_row(j, tile[k][0], tile[k][1], tile[k][2],
					tile[k][3], tile[k][4], tile[k][5]);
		for (int j = 0; j < 4; j++) begin
			r = '0;
			for (int c = 0; c < 4; c++)
				r = {r[47:0], qnt(a_row(c, mid[0][j], mid[1][j], mid[2][j],
					mid[3][j], mid[4][j], mid[5][j]))};
			exp_q.push_back(r);
		end
	endtask

	task automatic check_lane(int n, logic [15:0] exp_v, logic [15:0] got);
		if (got !== exp_v) begin
			$display("[ERROR] o_pix.p%0d expected %h got %h", n, exp_v, got);
			err_cnt++;
		end
	endtask

	// Collector compares rows in arrival order.
	always @(negedge clk) begin
		logic [63:0] e;
		if (o_valid) begin
			if (!prev_v) begin
				rise_cyc = cyc;
				run_len = 0;
			end
			run_len = run_len + 1;
			if (exp_q.size() == 0) begin
				$display("Output row arrived with no tile pending");
				err_cnt++;
			end else begin
				e = exp_q.pop_front();
				check_lane(0, e[63:48], o_pix.p0);
				check_lane(1, e[47:32], o_pix.p1);
				check_lane(2, e[31:16], o_pix.p2);
				check_lane(3, e[15:0], o_pix.p3);
			end
		end else if (prev_v) begin
			last_run = run_len;
		end
		prev_v = o_valid;
	end

	task automatic send_tile();
		for (int r = 0; r < 6; r++) begin
			@(negedge clk);
			if (r == 0) start_cyc = cyc + 1; // Sampled on the next rising edge.
			i_valid = 1'b1;
			i_row.m0 = tile[r][0];
			i_row.m1 = tile[r][1];
			i_row.m2 = tile[r][2];
			i_row.m3 = tile[r][3];
			i_row.m4 = tile[r][4];
			i_row.m5 = tile[r][5];
		end
	endtask

	task automatic idle();
		@(negedge clk);
		i_valid = 1'b0;
	endtask

	task automatic write_reg(logic addr, int val);
		@(negedge clk);
		i_cfg_we = 1'b1;
		i_cfg_addr = addr;
		i_cfg_wdata = 8'(val);
		@(negedge clk);
		i_cfg_we = 1'b0;
	endtask

	task automatic set_cfg(int sh, int rl);
		if (sh != cur_shift) write_reg(1'b0, sh);
		if (rl != cur_relu) write_reg(1'b1, rl);
		cur_shift = sh;
		cur_relu = rl;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (exp_q.size() != 0 && n < 200) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			$display("Timeout waiting for %0d output rows", exp_q.size());
			err_cnt++;
			exp_q.delete();
		end
	endtask

	task automatic random_tile();
		for (int r = 0; r < 6; r++)
			for (int c = 0; c < 6; c++)
				tile[r][c] = acc_t'($random(seed) % 262144);
	endtask

	task automatic end_test(string name);
		if (err_cnt == e0) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, err_cnt - e0);
		end
	endtask

	initial begin
		int b;
		seed = 32'h7ad4_a6df;
		clk = 1'b0;
		i_rst_n = 1'b0;
		i_valid = 1'b0;
		i_row = '0;
		i_cfg_we = 1'b0;
		i_cfg_addr = 1'b0;
		i_cfg_wdata = '0;
		{err_cnt, pass_cnt, fail_cnt, cyc, run_len, last_run} = '0;
		{start_cyc, rise_cyc} = '0;
		prev_v = 1'b0;
		cur_shift = `WINO_SHIFT_RST;
		cur_relu = `WINO_RELU_RST;
		$readmemh("tb/wino_inv_vectors.hex", vec);

		e0 = err_cnt;
		for (int n = 0; n < 23; n++) begin
			@(negedge clk);
			if (n == 2) i_rst_n = 1'b1;
			if (o_valid !== 1'b0) begin
				$display("[ERROR] o_valid expected 0 got %h at cycle %0d", o_valid, n);
				err_cnt++;
			end
		end
		end_test("reset");

		for (int rec = 0; rec < NREC; rec++) begin
			e0 = err_cnt;
			b = rec * RECW;
			set_cfg(int'(vec[b]), int'(vec[b+1]));
			for (int r = 0; r < 6; r++)
				for (int c = 0; c < 6; c++)
					tile[r][c] = vec[b+2+r*6+c][`WINO_ACC_W-1:0];
			for (int j = 0; j < 4; j++)
				exp_q.push_back({vec[b+38+j*4][15:0], vec[b+39+j*4][15:0],
					vec[b+40+j*4][15:0], vec[b+41+j*4][15:0]});
			send_tile();
			idle();
			drain();
			end_test($sformatf("vector record %0d", rec));
		end

		set_cfg(8, 1);
		e0 = err_cnt;
		for (int t = 0; t < 8; t++) begin
			random_tile();
			model_tile();
			send_tile();
		end
		idle();
		drain();
		end_test("streaming");

		e0 = err_cnt;
		random_tile();
		model_tile();
		send_tile();
		idle();
		drain();
		repeat (3) @(negedge clk);
		if (rise_cyc - start_cyc != 13) begin
			$display("o_valid rose %0d cycles after the first row, not 13", rise_cyc - start_cyc);
			err_cnt++;
		end
		if (last_run != 4) begin
			$display("o_valid stayed high for %0d cycles, not 4", last_run);
			err_cnt++;
		end
		end_test("latency");

		$display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* tb/wino_inv_vectors.hex */
// Record: shift and relu, six input rows of six words,
// then 16 expected pixels (p0..p3 of output rows 0 to 3).
8 1
123400 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
0 0 0 0 0 0
1234 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
8 1
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100 100 100
100 100 100 100 100 100
19 0 32 5 0 0 0 0 32 0 64 a 5 0 a 1
8 1
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
8 0
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffffff00 ffffff00 ffffff00 ffffff00 ffffff00 ffffff00
ffe7 0 ffce fffb 0 0 0 0 ffce 0 ff9c fff6 fffb 0 fff6 ffff
0 0
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
7fff 0 7fff 7fff 0 0 0 0 7fff 0 7fff 7fff 7fff 0 7fff 7fff
0 0
ffff0000 ffff0000 ffff0000 ffff0000 ffff0000 ffff0000
ffff0000 ffff0000 ffff0000 ffff0000 ffff0000 ffff0000
ffff0000 ffff0000 ffff0000 ffff0000 ffff0000 ffff0000
ffff0000 ffff0000 ffff0000 ffff0000 ffff0000 ffff0000
ffff0000 ffff0000 ffff0000 ffff0000 ffff0000 ffff0000
ffff0000 ffff0000 ffff0000 ffff0000 ffff0000 ffff0000
8000 0 8000 8000 0 0 0 0 8000 0 8000 8000 8000 0 8000 8000
f 1
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
10000 10000 10000 10000 10000 10000
32 0 64 a 0 0 0 0 64 0 c8 14 a 0 14 2

/* verilog/wino_add6.sv */
`timescale 1ns/10ps
`include "wino_consts.svh"

module wino_add6 import wino_pkg::*; (
	input  logic clk,
	input  logic i_rst_n,
	input  acc_t i_a0,
	input  acc_t i_a1,
	input  acc_t i_a2,
	input  acc_t i_a3,
	input  acc_t i_a4,
	input  acc_t i_a5,
	output acc_t o_sum
);

	acc_t s1_0, s1_1, s1_2;
	acc_t s2_0, s2_1;
	acc_t s3;

	// Sums wrap at the word width.
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			s1_0 <= '0;
			s1_1 <= '0;
			s1_2 <= '0;
			s2_0 <= '0;
			s2_1 <= '0;
			s3 <= '0;
		end else begin
			s1_0 <= i_a0 + i_a1;
			s1_1 <= i_a2 + i_a3;
			s1_2 <= i_a4 + i_a5;
			s2_0 <= s1_0 + s1_1;
			s2_1 <= s1_2; // Odd operand just rides along.
			s3 <= s2_0 + s2_1;
		end
	end

	assign o_sum = s3;

endmodule

/* verilog/wino_cfg_regs.sv */
`timescale 1ns/10ps
`include "wino_consts.svh"

module wino_cfg_regs import wino_pkg::*; (
	input  logic            clk,
	input  logic            i_rst_n,
	input  logic            i_cfg_we,
	input  logic            i_cfg_addr,
	input  logic [7:0]      i_cfg_wdata,
	output wino_quant_cfg_t o_cfg
);

	logic [3:0] shift_q;
	logic relu_q;

	// Address 0 is the shift, address 1 the ReLU enable.
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			shift_q <= 4'(`WINO_SHIFT_RST);
			relu_q <= 1'(`WINO_RELU_RST);
		end else if (i_cfg_we) begin
			if (i_cfg_addr == 1'b0) begin
				shift_q <= i_cfg_wdata[3:0]; // Upper nibble dropped.
			end else begin
				relu_q <= i_cfg_wdata[0];
			end
		end
	end

	assign o_cfg.shift = shift_q;
	assign o_cfg.relu = relu_q;

endmodule

/* verilog/wino_consts.svh */
`ifndef WINO_CONSTS_SVH
`define WINO_CONSTS_SVH

// Datapath widths.
`define WINO_ACC_W 30
`define WINO_PIX_W 16

// Tile geometry for F(4,3).
`define WINO_IN_ROWS 6
`define WINO_OUT_ROWS 4

// Quantizer defaults after reset.
`define WINO_SHIFT_RST 8
`define WINO_RELU_RST 1

`endif

/* verilog/wino_inv_top.sv */
`timescale 1ns/10ps
`include "wino_consts.svh"

module wino_inv_top import wino_pkg::*; (
	input  logic          clk,
	input  logic          i_rst_n,
	input  logic          i_valid,
	input  wino_row_t     i_row,
	input  logic          i_cfg_we,
	input  logic          i_cfg_addr,
	input  logic [7:0]    i_cfg_wdata,
	output logic          o_valid,
	output wino_pix_row_t o_pix
);

	wino_quant_cfg_t cfg;
	logic col_valid;
	wino_sum_row_t col_sum;
	logic ser_valid;
	wino_row_t ser_row;
	logic row_valid;
	wino_sum_row_t row_sum;

	wino_cfg_regs u_cfg (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_cfg_we(i_cfg_we),
		.i_cfg_addr(i_cfg_addr),
		.i_cfg_wdata(i_cfg_wdata),
		.o_cfg(cfg)
	);

	// First pass runs on each incoming row.
	wino_row_xform col_pass (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_valid(i_valid),
		.i_row(i_row),
		.o_valid(col_valid),
		.o_sum(col_sum)
	);

	wino_transpose u_transpose (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_valid(col_valid),
		.i_sum(col_sum),
		.o_valid(ser_valid),
		.o_row(ser_row)
	);

	wino_row_xform row_pass (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_valid(ser_valid),
		.i_row(ser_row),
		.o_valid(row_valid),
		.o_sum(row_sum)
	);

	wino_out_quant u_quant (
		.clk(clk),
		.i_rst_n(i_rst_n),
		.i_cfg(cfg),
		.i_valid(row_valid),
		.i_sum(row_sum),
		.o_valid(o_valid),
		.o_pix(o_pix)
	);

endmodule

/* verilog/wino_out_quant.sv */
`timescale 1ns/10ps
`include "wino_consts.svh"

module wino_out_quant import wino_pkg::*; (
	input  logic            clk,
	input  logic            i_rst_n,
	input  wino_quant_cfg_t i_cfg,
	input  logic            i_valid,
	input  wino_sum_row_t   i_sum,
	output logic            o_valid,
	output wino_pix_row_t   o_pix
);

	localparam acc_t PIX_MAX = acc_t'((1 << (`WINO_PIX_W - 1)) - 1);
	localparam acc_t PIX_MIN = -PIX_MAX - acc_t'(1);

	// ReLU, then shift, then clamp to pixel range.
	function automatic logic signed [`WINO_PIX_W-1:0] quant(acc_t v, wino_quant_cfg_t cfg);
		acc_t sh;
		logic signed [`WINO_PIX_W-1:0] res;
		sh = v >>> cfg.shift;
		if (cfg.relu && v < 0)
			res = '0;
		else if (sh > PIX_MAX)
			res = PIX_MAX[`WINO_PIX_W-1:0];
		else if (sh < PIX_MIN)
			res = PIX_MIN[`WINO_PIX_W-1:0];
		else
			res = sh[`WINO_PIX_W-1:0];
		return res;
	endfunction

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) o_valid <= 1'b0;
		else o_valid <= i_valid;
	end

	always_ff @(posedge clk) begin
		o_pix.p0 <= quant(i_sum.y0, i_cfg);
		o_pix.p1 <= quant(i_sum.y1, i_cfg);
		o_pix.p2 <= quant(i_sum.y2, i_cfg);
		o_pix.p3 <= quant(i_sum.y3, i_cfg);
	end

	// Shift and ReLU must hold across a tile's rows.
	a_cfg_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
		(i_valid && $past(i_valid)) |-> $stable(i_cfg));

endmodule

/* verilog/wino_pkg.sv */
`include "wino_consts.svh"

package wino_pkg;

	typedef logic signed [`WINO_ACC_W-1:0] acc_t;

	// One input row, or one transposed row fed to the row pass.
	typedef struct packed {
		acc_t m0;
		acc_t m1;
		acc_t m2;
		acc_t m3;
		acc_t m4;
		acc_t m5;
	} wino_row_t;

	typedef struct packed {
		acc_t y0;
		acc_t y1;
		acc_t y2;
		acc_t y3;
	} wino_sum_row_t;

	typedef struct packed {
		logic signed [`WINO_PIX_W-1:0] p0;
		logic signed [`WINO_PIX_W-1:0] p1;
		logic signed [`WINO_PIX_W-1:0] p2;
		logic signed [`WINO_PIX_W-1:0] p3;
	} wino_pix_row_t;

	typedef struct packed {
		logic [3:0] shift; // Arithmetic right shift amount.
		logic relu;
	} wino_quant_cfg_t;

endpackage

/* verilog/wino_row_xform.sv */
`timescale 1ns/10ps
`include "wino_consts.svh"

module wino_row_xform import wino_pkg::*; (
	input  logic          clk,
	input  logic          i_rst_n,
	input  logic          i_valid,
	input  wino_row_t     i_row,
	output logic          o_valid,
	output wino_sum_row_t o_sum
);

	acc_t m2_neg;
	acc_t m3_x2, m3_x4, m3_x8;
	acc_t m4_x2n, m4_x4, m4_x8n;
	logic [2:0] vld_sr;

	// Weighted operands of the A transpose rows.
	assign m2_neg = -i_row.m2;
	assign m3_x2 = i_row.m3 << 1;
	assign m3_x4 = i_row.m3 << 2;
	assign m3_x8 = i_row.m3 << 3;
	assign m4_x2n = -(i_row.m4 << 1);
	assign m4_x4 = i_row.m4 << 2;
	assign m4_x8n = -(i_row.m4 << 3);

	wino_add6 u_add_y0 (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_a0(i_row.m0), .i_a1(i_row.m1), .i_a2(i_row.m2),
		.i_a3(i_row.m3), .i_a4(i_row.m4), .i_a5('0),
		.o_sum(o_sum.y0)
	);

	wino_add6 u_add_y1 (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_a0('0), .i_a1(i_row.m1), .i_a2(m2_neg),
		.i_a3(m3_x2), .i_a4(m4_x2n), .i_a5('0),
		.o_sum(o_sum.y1)
	);

	wino_add6 u_add_y2 (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_a0('0), .i_a1(i_row.m1), .i_a2(i_row.m2),
		.i_a3(m3_x4), .i_a4(m4_x4), .i_a5('0),
		.o_sum(o_sum.y2)
	);

	wino_add6 u_add_y3 (
		.clk(clk), .i_rst_n(i_rst_n),
		.i_a0('0), .i_a1(i_row.m1), .i_a2(m2_neg),
		.i_a3(m3_x8), .i_a4(m4_x8n), .i_a5(i_row.m5),
		.o_sum(o_sum.y3)
	);

	// Matches the adder tree depth.
	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[1:0], i_valid};
		end
	end

	assign o_valid = vld_sr[2];

endmodule

/* verilog/wino_transpose.sv */
`timescale 1ns/10ps
`include "wino_consts.svh"

module wino_transpose import wino_pkg::*; (
	input  logic          clk,
	input  logic          i_rst_n,
	input  logic          i_valid,
	input  wino_sum_row_t i_sum,
	output logic          o_valid,
	output wino_row_t     o_row
);

	localparam logic [2:0] LAST_COL = 3'(`WINO_IN_ROWS - 1);
	localparam logic [1:0] LAST_OUT = 2'(`WINO_OUT_ROWS - 1);

	wino_sum_row_t col_arr [0:`WINO_IN_ROWS-1];
	wino_sum_row_t ser_buf [0:`WINO_IN_ROWS-1];
	logic [2:0] col_cnt;
	logic [1:0] out_cnt;
	logic load_pend; // Whole tile collected.
	logic busy;

	function automatic acc_t pick(wino_sum_row_t s, logic [1:0] j);
		acc_t r;
		case (j)
			2'd0: r = s.y0;
			2'd1: r = s.y1;
			2'd2: r = s.y2;
			default: r = s.y3;
		endcase
		return r;
	endfunction

	always_ff @(posedge clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			col_cnt <= '0;
			load_pend <= 1'b0;
			busy <= 1'b0;
			out_cnt <= '0;
		end else begin
			load_pend <= i_valid && (col_cnt == LAST_COL);
			if (i_valid) begin
				col_cnt <= (col_cnt == LAST_COL) ? 3'd0 : col_cnt + 3'd1;
			end
			// A fresh load restarts emission from row 0.
			if (load_pend) begin
				busy <= 1'b1;
				out_cnt <= '0;
			end else if (busy) begin
				out_cnt <= out_cnt + 2'd1;
				if (out_cnt == LAST_OUT) begin
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_valid) begin
			col_arr[col_cnt] <= i_sum;
		end
		if (load_pend) begin
			ser_buf <= col_arr; // Frees the collect side for the next tile.
		end
	end

	// Row j of the buffer is yj taken from each column result.
	always_comb begin
		o_row.m0 = pick(ser_buf[0], out_cnt);
		o_row.m1 = pick(ser_buf[1], out_cnt);
		o_row.m2 = pick(ser_buf[2], out_cnt);
		o_row.m3 = pick(ser_buf[3], out_cnt);
		o_row.m4 = pick(ser_buf[4], out_cnt);
		o_row.m5 = pick(ser_buf[5], out_cnt);
	end

	assign o_valid = busy;

	// A valid run always ends on a tile boundary.
	a_whole_tiles: assert property (@(posedge clk) disable iff (!i_rst_n)
		(!i_valid && $past(i_valid)) |-> (col_cnt == 3'd0));

endmodule

/* wino_inv_top.f */
+incdir+verilog
verilog/wino_pkg.sv
verilog/wino_add6.sv
verilog/wino_row_xform.sv
verilog/wino_transpose.sv
verilog/wino_out_quant.sv
verilog/wino_cfg_regs.sv
verilog/wino_inv_top.sv
tb/tb_wino_inv.sv
